/* rtl/deconv_pkg.sv */
package deconv_pkg;

    //////////////////////////////
    // Map and kernel geometry
    //////////////////////////////

    localparam int FEAT_SIZE  = 4;                          // Feature map side
    localparam int KERN_SIZE  = 3;                          // Kernel side
    localparam int OUT_SIZE   = FEAT_SIZE + KERN_SIZE - 1;  // Stride 1 full transposed conv
    localparam int OUT_PIXELS = OUT_SIZE * OUT_SIZE;        // Results per run

    localparam int FEAT_DEPTH = FEAT_SIZE * FEAT_SIZE;
    localparam int KERN_DEPTH = KERN_SIZE * KERN_SIZE;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int ADDR_W = 4;                              // Covers the feature store
    localparam int PIX_W  = 8;
    localparam int ACC_W  = 20;                             // 9 taps of 8x8 products

    localparam int OUT_IDX_W    = $clog2(OUT_SIZE);         // Output row / column counter
    localparam int KERN_IDX_W   = $clog2(KERN_SIZE);        // Kernel row / column counter
    localparam int RESULT_CNT_W = $clog2(OUT_PIXELS);

    //////////////////////////////
    // Result flow control
    //////////////////////////////

    localparam int OUT_CREDITS = 4;                         // Granted by consumer after reset
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic signed [PIX_W-1:0]  pixel_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic        [ADDR_W-1:0] mem_addr_t;

endpackage

/* rtl/deconv_operand_mem.sv */
module deconv_operand_mem
    import deconv_pkg::*;
#(
    parameter int DEPTH = FEAT_DEPTH
)
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    // Host write port
    input  logic      i_we,
    input  mem_addr_t i_waddr,
    input  pixel_t    i_wdata,

    // Sequencer read port
    input  mem_addr_t i_raddr,
    output pixel_t    o_rdata
);

    pixel_t mem [DEPTH];                                    // Row-major operand storage

    //////////////////////////////
    // Host write
    //////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_we && (int'(i_waddr) < DEPTH))                // Drop writes past the last entry
        begin
            mem[i_waddr] <= i_wdata;
        end
    end

    //////////////////////////////
    // Registered read
    //////////////////////////////

    // Data for an address presented in cycle t shows up in cycle t+1, which
    // is what the MAC flag delay assumes
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_rdata <= '0;
        end
        else
        begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

/* rtl/deconv_tap_sequencer.sv */
module deconv_tap_sequencer
    import deconv_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  logic      i_start,
    input  logic      i_credit_return,                      // One pulse per consumed result
    output logic      o_busy,

    // Tap stream towards the stores and the MAC
    output logic      o_tap_valid,
    output logic      o_tap_zero,
    output logic      o_tap_first,
    output logic      o_tap_last,
    output mem_addr_t o_feat_addr,
    output mem_addr_t o_kern_addr
);

    localparam logic [OUT_IDX_W-1:0]  OUT_LAST  = OUT_IDX_W'(OUT_SIZE - 1);
    localparam logic [KERN_IDX_W-1:0] KERN_LAST = KERN_IDX_W'(KERN_SIZE - 1);

    logic                  running;
    logic [OUT_IDX_W-1:0]  out_r;                           // Output pixel row
    logic [OUT_IDX_W-1:0]  out_c;                           // Output pixel column
    logic [KERN_IDX_W-1:0] k_r;                             // Tap row within kernel
    logic [KERN_IDX_W-1:0] k_c;                             // Tap column within kernel
    logic [CREDIT_W-1:0]   credits;

    logic                  tap0;
    logic                  tap_end;
    logic                  run_end;
    logic                  issue;
    logic                  spend;
    logic                  row_out;
    logic                  col_out;
    logic [OUT_IDX_W-1:0]  feat_r;
    logic [OUT_IDX_W-1:0]  feat_c;

    assign tap0    = (k_r == '0) && (k_c == '0);
    assign tap_end = (k_r == KERN_LAST) && (k_c == KERN_LAST);
    assign run_end = tap_end && (out_r == OUT_LAST) && (out_c == OUT_LAST);

    // A new pixel needs a free credit, an open one runs to its last tap
    assign issue = running && (!tap0 || (credits != '0));
    assign spend = issue && tap0;

    //////////////////////////////
    // Run control
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            running <= 1'b0;
        end
        else if (!running && i_start)                       // Start while busy is ignored
        begin
            running <= 1'b1;
        end
        else if (issue && run_end)
        begin
            running <= 1'b0;
        end
    end

    //////////////////////////////
    // Tap and pixel counters
    //////////////////////////////

    // All counters wrap to zero on the final tap, so a new run starts clean
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            k_r   <= '0;
            k_c   <= '0;
            out_r <= '0;
            out_c <= '0;
        end
        else if (issue)
        begin
            if (k_c == KERN_LAST)
            begin
                k_c <= '0;
                if (k_r == KERN_LAST)
                begin
                    k_r <= '0;
                    if (out_c == OUT_LAST)
                    begin
                        out_c <= '0;
                        out_r <= (out_r == OUT_LAST) ? '0 : out_r + 1'b1;
                    end
                    else
                    begin
                        out_c <= out_c + 1'b1;
                    end
                end
                else
                begin
                    k_r <= k_r + 1'b1;
                end
            end
            else
            begin
                k_c <= k_c + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Credits
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            credits <= CREDIT_W'(OUT_CREDITS);
        end
        else
        begin
            credits <= credits + CREDIT_W'(i_credit_return) - CREDIT_W'(spend);
        end
    end

    //////////////////////////////
    // Address and range check
    //////////////////////////////

    assign row_out = (out_r < k_r) || (int'(out_r) >= int'(k_r) + FEAT_SIZE);
    assign col_out = (out_c < k_c) || (int'(out_c) >= int'(k_c) + FEAT_SIZE);
    assign feat_r  = out_r - OUT_IDX_W'(k_r);
    assign feat_c  = out_c - OUT_IDX_W'(k_c);

    assign o_feat_addr = (row_out || col_out) ? '0
                                              : mem_addr_t'(feat_r * FEAT_SIZE + feat_c);
    assign o_kern_addr = mem_addr_t'(k_r * KERN_SIZE + k_c);

    assign o_busy      = running;
    assign o_tap_valid = issue;
    assign o_tap_zero  = issue && (row_out || col_out);  // Feature index off the map
    assign o_tap_first = spend;
    assign o_tap_last  = issue && tap_end;

endmodule

/* rtl/deconv_mac.sv */
module deconv_mac
    import deconv_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,

    input  logic   i_tap_valid,
    input  logic   i_tap_zero,
    input  logic   i_tap_first,
    input  logic   i_tap_last,
    input  pixel_t i_feat,                                  // Arrives one cycle after the flags
    input  pixel_t i_kern,

    output logic   o_out_valid,
    output logic   o_out_last,
    output acc_t   o_out_pixel
);

    logic                      d_valid;
    logic                      d_zero;
    logic                      d_first;
    logic                      d_last;
    logic signed [2*PIX_W-1:0] prod;
    acc_t                      acc;
    acc_t                      sum_next;
    logic [RESULT_CNT_W-1:0]   res_cnt;
    logic                      res_done;

    // Line the flags up with the store read data
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            d_valid <= 1'b0;
            d_zero  <= 1'b0;
            d_first <= 1'b0;
            d_last  <= 1'b0;
        end
        else
        begin
            d_valid <= i_tap_valid;
            d_zero  <= i_tap_zero;
            d_first <= i_tap_first;
            d_last  <= i_tap_last;
        end
    end

    assign prod     = i_feat * i_kern;
    assign sum_next = (d_first ? acc_t'(0) : acc)           // First tap restarts sum
                    + (d_zero ? acc_t'(0) : acc_t'(prod));   // Zero tap adds nothing
    assign res_done = d_valid && d_last;

    always_ff @(posedge i_clk)
    begin
        if (d_valid)
        begin
            acc <= sum_next;
        end
        if (res_done)
        begin
            o_out_pixel <= sum_next;
        end
    end

    //////////////////////////////
    // Result strobe and framing
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_out_valid <= 1'b0;
            o_out_last  <= 1'b0;
            res_cnt     <= '0;
        end
        else
        begin
            o_out_valid <= res_done;
            o_out_last  <= res_done && (res_cnt == RESULT_CNT_W'(OUT_PIXELS - 1));
            if (res_done)
            begin
                res_cnt <= (res_cnt == RESULT_CNT_W'(OUT_PIXELS - 1)) ? '0 : res_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/deconv_core_top.sv */
module deconv_core_top
    import deconv_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  logic      i_start,
    input  logic      i_wr_en,
    input  logic      i_wr_sel,                             // 0 feature, 1 weight
    input  mem_addr_t i_wr_addr,
    input  pixel_t    i_wr_data,
    input  logic      i_credit_return,

    output logic      o_busy,
    output logic      o_out_valid,
    output logic      o_out_last,
    output acc_t      o_out_pixel
);

    logic      tap_valid;
    logic      tap_zero;
    logic      tap_first;
    logic      tap_last;
    mem_addr_t feat_addr;
    mem_addr_t kern_addr;
    pixel_t    feat_data;
    pixel_t    kern_data;
    logic      feat_we;
    logic      kern_we;

    assign feat_we = i_wr_en && !i_wr_sel;
    assign kern_we = i_wr_en && i_wr_sel;

    //////////////////////////////
    // Stage 1 tap sequencer
    //////////////////////////////

    deconv_tap_sequencer seq0 (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_credit_return (i_credit_return),
        .o_busy          (o_busy),
        .o_tap_valid     (tap_valid),
        .o_tap_zero      (tap_zero),
        .o_tap_first     (tap_first),
        .o_tap_last      (tap_last),
        .o_feat_addr     (feat_addr),
        .o_kern_addr     (kern_addr)
    );

    //////////////////////////////
    // Stage 2 operand stores
    //////////////////////////////

    deconv_operand_mem #(.DEPTH(FEAT_DEPTH)) feat_mem (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (feat_we),
        .i_waddr (i_wr_addr),
        .i_wdata (i_wr_data),
        .i_raddr (feat_addr),
        .o_rdata (feat_data)
    );

    deconv_operand_mem #(.DEPTH(KERN_DEPTH)) kern_mem (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (kern_we),
        .i_waddr (i_wr_addr),
        .i_wdata (i_wr_data),
        .i_raddr (kern_addr),
        .o_rdata (kern_data)
    );

    //////////////////////////////
    // Stage 3 accumulator
    //////////////////////////////

    deconv_mac mac0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tap_valid (tap_valid),
        .i_tap_zero  (tap_zero),
        .i_tap_first (tap_first),
        .i_tap_last  (tap_last),
        .i_feat      (feat_data),
        .i_kern      (kern_data),
        .o_out_valid (o_out_valid),
        .o_out_last  (o_out_last),
        .o_out_pixel (o_out_pixel)
    );

endmodule

/* tb/deconv_props.sv */
module deconv_props
    import deconv_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input logic i_credit_return,
    input logic i_busy,
    input logic i_out_valid,
    input logic i_out_last
);

    int unsigned fail_cnt = 0;                          // Read by the testbench
    int          outstanding;                           // Results not yet paid back
    int          run_results;                           // Results so far in this run

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            outstanding <= 0;
            run_results <= 0;
        end
        else
        begin
            outstanding <= outstanding + int'(i_out_valid) - int'(i_credit_return);
            if (i_out_valid)
                run_results <= i_out_last ? 0 : run_results + 1;
        end
    end

    //////////////////////////////
    // Reset state
    //////////////////////////////

    assert property (@(posedge i_clk) !i_rst_n |-> !i_busy && !i_out_valid && !i_out_last)
    else
    begin
        fail_cnt++;
        $error("outputs not low during reset");
    end

    assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_busy && !i_out_valid && !i_out_last)
    else
    begin
        fail_cnt++;
        $error("outputs not low right after reset");
    end

    //////////////////////////////
    // Credits and framing
    //////////////////////////////

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
                     outstanding + int'(i_out_valid) <= OUT_CREDITS)
    else
    begin
        fail_cnt++;
        $error("more results in flight than credits granted");
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_out_last |-> i_out_valid)
    else
    begin
        fail_cnt++;
        $error("last flag without a valid result");
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
                     i_out_valid |-> (i_out_last == (run_results == OUT_PIXELS - 1)))
    else
    begin
        fail_cnt++;
        $error("last flag not on the final result of a run");
    end

endmodule

bind deconv_core_top deconv_props props0 (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_credit_return (i_credit_return),
    .i_busy          (o_busy),
    .i_out_valid     (o_out_valid),
    .i_out_last      (o_out_last)
);

/* tb/deconv_tb.sv */
module deconv_tb
    import deconv_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int RUNS            = 3;
    localparam int RUN_CYCLES      = OUT_PIXELS * KERN_DEPTH * 4;  // Credit stalls included
    localparam int LOAD_CYCLES     = FEAT_DEPTH + KERN_DEPTH;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUNS * (RUN_CYCLES + LOAD_CYCLES) + 100;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_start;
    logic      i_wr_en;
    logic      i_wr_sel;
    mem_addr_t i_wr_addr;
    pixel_t    i_wr_data;
    logic      i_credit_return;
    logic      o_busy;
    logic      o_out_valid;
    logic      o_out_last;
    acc_t      o_out_pixel;

    int          seed = 32'hca76;
    pixel_t      feat [FEAT_DEPTH];                     // Host copy of the stores
    pixel_t      kern [KERN_DEPTH];
    acc_t        exp_q [$];
    acc_t        expected;
    int          runs_done = 0;
    bit          slow_consumer = 1'b0;
    int unsigned release_q [$];                         // Cycles at which credits go back
    int unsigned cyc = 0;
    int unsigned delay;
    int unsigned due;

    deconv_core_top dut0 (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic load_store(input logic sel, input int depth);
        pixel_t val;
        for (int a = 0; a < depth; a++)
        begin
            @(negedge i_clk);
            val       = pixel_t'($random(seed));
            i_wr_en   = 1'b1;
            i_wr_sel  = sel;
            i_wr_addr = mem_addr_t'(a);
            i_wr_data = val;
            if (sel)
                kern[a] = val;
            else
                feat[a] = val;
        end
        @(negedge i_clk);
        i_wr_en = 1'b0;
    endtask

    // Full transposed convolution as out[r][c] = sum of feat[r-i][c-j] * kern[i][j]
    task automatic build_expected();
        int sum;
        int fr;
        int fc;
        for (int r = 0; r < OUT_SIZE; r++)
        begin
            for (int c = 0; c < OUT_SIZE; c++)
            begin
                sum = 0;
                for (int i = 0; i < KERN_SIZE; i++)
                begin
                    for (int j = 0; j < KERN_SIZE; j++)
                    begin
                        fr = r - i;
                        fc = c - j;
                        if (fr >= 0 && fr < FEAT_SIZE && fc >= 0 && fc < FEAT_SIZE)
                            sum += int'(feat[fr * FEAT_SIZE + fc])
                                 * int'(kern[i * KERN_SIZE + j]);
                    end
                end
                exp_q.push_back(acc_t'(sum));
            end
        end
    endtask

    task automatic pulse_start();
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    //////////////////////////////
    // Result checks
    //////////////////////////////

    always @(negedge i_clk)
    begin
        if (i_rst_n && o_out_valid === 1'b1)
        begin
            assert (exp_q.size() != 0)
            begin
                expected = exp_q.pop_front();
                assert (o_out_pixel == expected)
                else abort_run($sformatf(
                    "mismatch at time %0t: o_out_pixel = %0d, expected %0d",
                    $time, o_out_pixel, expected));
                if (o_out_last)
                begin
                    assert (exp_q.size() == 0)
                    else abort_run("run ended before all of its results had arrived");
                    runs_done++;
                end
            end
            else abort_run("a result arrived while no result was expected");
        end
    end

    // Fails from the bound properties end the run here
    always @(negedge i_clk)
    begin
        if (dut0.props0.fail_cnt != 0)
            abort_run("a bound property check failed");
    end

    //////////////////////////////
    // Credit returning consumer
    //////////////////////////////

    always @(negedge i_clk)
    begin
        cyc++;
        i_credit_return = 1'b0;
        if (release_q.size() != 0 && release_q[0] <= cyc)
        begin
            void'(release_q.pop_front());
            i_credit_return = 1'b1;
        end
        if (o_out_valid === 1'b1)
        begin
            delay = $unsigned($random(seed)) % (slow_consumer ? 31 : 7);
            due   = cyc + delay;
            if (release_q.size() != 0 && due <= release_q[$])
                due = release_q[$] + 1;                 // One return per cycle
            release_q.push_back(due);
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout, the runs did not finish in the allowed time");
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        i_rst_n         = 1'b0;
        i_start         = 1'b0;
        i_wr_en         = 1'b0;
        i_wr_sel        = 1'b0;
        i_wr_addr       = '0;
        i_wr_data       = '0;
        i_credit_return = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        load_store(1'b0, FEAT_DEPTH);                   // Run 1 on fresh operands
        load_store(1'b1, KERN_DEPTH);
        build_expected();
        pulse_start();
        wait (runs_done == 1);

        load_store(1'b1, KERN_DEPTH);                   // Run 2 with new weights and a stray start
        build_expected();
        pulse_start();
        repeat (20) @(negedge i_clk);
        assert (o_busy)
        else abort_run("the second start pulse was not issued during a run");
        pulse_start();
        wait (runs_done == 2);

        load_store(1'b1, KERN_DEPTH);
        build_expected();
        slow_consumer = 1'b1;                           // Run 3 holds credits back
        pulse_start();
        wait (runs_done == RUNS);
        wait (release_q.size() == 0);
        repeat (4) @(negedge i_clk);

        if (dut0.props0.fail_cnt != 0)
        begin
            $display("STATUS: FAIL");
            $fatal(1);
        end
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* tb.f */
rtl/deconv_pkg.sv
rtl/deconv_operand_mem.sv
rtl/deconv_tap_sequencer.sv
rtl/deconv_mac.sv
rtl/deconv_core_top.sv
tb/deconv_props.sv
tb/deconv_tb.sv

/* Bender.yml */
package:
  name: deconv_core

sources:
  - rtl/deconv_pkg.sv
  - rtl/deconv_operand_mem.sv
  - rtl/deconv_tap_sequencer.sv
  - rtl/deconv_mac.sv
  - rtl/deconv_core_top.sv
  - target: simulation
    files:
      - tb/deconv_props.sv
      - tb/deconv_tb.sv
